//--- list.f
verilog/dma_stats_pkg.sv
verilog/stats_dma_latency.sv
verilog/stats_record_fifo.sv
verilog/stats_credit_tx.sv
verilog/stats_accum.sv
verilog/dma_stats_top.sv
dv/dma_stats_tb.sv

//--- Makefile
# Verilator flow for the DMA completion statistics block

VERILATOR  ?= verilator
TOP        ?= dma_stats_tb
RTL_TOP    ?= dma_stats_top
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= test passed
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall

RTL_SRCS = verilog/dma_stats_pkg.sv \
           verilog/stats_dma_latency.sv \
           verilog/stats_record_fifo.sv \
           verilog/stats_credit_tx.sv \
           verilog/stats_accum.sv \
           verilog/dma_stats_top.sv

TB_SRCS = dv/dma_stats_tb.sv

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/dma_stats_tb.sv
`timescale 1ns/10ps

module dma_stats_tb;

    import dma_stats_pkg::*;

    localparam int TIMEOUT_CYCLES = 3000;             // about 10x the full directed run
    localparam int BURST          = FIFO_DEPTH + 3;   // overflow burst, 3 past depth

    typedef struct packed {
        logic [TAG_WIDTH-1:0]    tag;
        logic [LEN_WIDTH-1:0]    len;
        logic [STATUS_WIDTH-1:0] status;
        logic [COUNT_WIDTH-1:0]  latency;
    } rec_t;

    logic                       clk;
    logic                       rst;
    logic [TAG_WIDTH-1:0]       start_tag;
    logic [LEN_WIDTH-1:0]       start_len;
    logic                       start_valid;
    logic [TAG_WIDTH-1:0]       finish_tag;
    logic [STATUS_WIDTH-1:0]    finish_status;
    logic                       finish_valid;
    logic                       stat_rd;
    logic [STAT_ADDR_WIDTH-1:0] stat_addr;
    logic [STAT_WIDTH-1:0]      stat_data;
    logic                       stat_data_valid;
    logic                       rec_credit;
    logic [TAG_WIDTH-1:0]       rec_tag;
    logic [LEN_WIDTH-1:0]       rec_len;
    logic [STATUS_WIDTH-1:0]    rec_status;
    logic [COUNT_WIDTH-1:0]     rec_latency;
    logic                       rec_valid;

    // reference model
    logic [COUNT_WIDTH-1:0] model_count;              // tracks the dut cycle counter
    logic [LEN_WIDTH-1:0]   len_model   [TAG_DEPTH];
    logic [COUNT_WIDTH-1:0] start_model [TAG_DEPTH];
    rec_t                   exp_q [$];                // records due at the consumer
    logic [STAT_WIDTH-1:0]  m_completions = '0;       // mirror statistics
    logic [STAT_WIDTH-1:0]  m_bytes       = '0;
    logic [STAT_WIDTH-1:0]  m_errors      = '0;
    logic [STAT_WIDTH-1:0]  m_lat_sum     = '0;
    logic [STAT_WIDTH-1:0]  m_lat_max     = '0;
    logic [STAT_WIDTH-1:0]  m_drops       = '0;

    int rec_count        = 0;                         // records seen on rec_valid
    int rec_target       = 0;                         // records expected in total
    int credits_returned = 0;
    int cycle_count      = 0;

    dma_stats_top dma_stats_top_i (.*);

    always #20 clk = ~clk;                            // 40 ns period

    always @(posedge clk) begin
        if (rst) begin
            model_count <= '0;
        end else begin
            model_count <= model_count + 1'b1;
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_run("timeout, the tests did not finish within the cycle limit");
        end
    end

    task automatic check_record(input rec_t exp, input logic [TAG_WIDTH-1:0] tag,
                                input logic [LEN_WIDTH-1:0] len,
                                input logic [STATUS_WIDTH-1:0] status,
                                input logic [COUNT_WIDTH-1:0] latency);
        if (tag !== exp.tag || len !== exp.len || status !== exp.status ||
            latency !== exp.latency) begin
            stop_run($sformatf("FAIL %0t: record %0d %0d %0d %0d, expected %0d %0d %0d %0d",
                $time, tag, len, status, latency, exp.tag, exp.len, exp.status, exp.latency));
        end
    endtask

    task automatic check_stat(input logic [STAT_ADDR_WIDTH-1:0] addr,
                              input logic [STAT_WIDTH-1:0] exp,
                              input logic [STAT_WIDTH-1:0] got);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %0t: statistic %0d read %0d, expected %0d",
                $time, addr, got, exp));
        end
    endtask

    // consumer side, outputs stable at the falling edge
    always @(negedge clk) begin : record_monitor
        rec_t exp;
        if (!rst && rec_valid) begin
            if (exp_q.size() == 0) begin
                stop_run("a record came out that no finish event should have produced");
            end else begin
                exp = exp_q.pop_front();
                check_record(exp, rec_tag, rec_len, rec_status, rec_latency);
            end
            rec_count++;
        end
    end

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic drive_start(input logic [TAG_WIDTH-1:0] tag, input logic [LEN_WIDTH-1:0] len);
        @(negedge clk);
        start_tag        = tag;
        start_len        = len;
        start_valid      = 1'b1;
        len_model[tag]   = len;
        start_model[tag] = model_count;               // count seen by the sampling edge
        @(negedge clk);
        start_valid = 1'b0;
    endtask

    // kept low means the fifo is expected to drop this record
    task automatic drive_finish(input logic [TAG_WIDTH-1:0] tag,
                                input logic [STATUS_WIDTH-1:0] status, input bit kept);
        rec_t r;
        @(negedge clk);
        finish_tag    = tag;
        finish_status = status;
        finish_valid  = 1'b1;
        r.tag         = tag;
        r.len         = len_model[tag];
        r.status      = status;
        r.latency     = model_count - start_model[tag];  // wraps mod 2^16
        if (kept) begin
            exp_q.push_back(r);
            rec_target++;
        end else begin
            m_drops++;
        end
        m_completions++;                              // every finish counts, dropped or not
        m_bytes   += STAT_WIDTH'(r.len);
        m_lat_sum += STAT_WIDTH'(r.latency);
        if (status != '0) begin
            m_errors++;
        end
        if (STAT_WIDTH'(r.latency) > m_lat_max) begin
            m_lat_max = STAT_WIDTH'(r.latency);
        end
        @(negedge clk);
        finish_valid = 1'b0;
    endtask

    task automatic return_credits(input int n);
        repeat (n) begin
            @(negedge clk);
            rec_credit = 1'b1;                        // one pulse per credit
            @(negedge clk);
            rec_credit = 1'b0;
            credits_returned++;
        end
    endtask

    task automatic wait_records(input int target);
        while (rec_count < target) @(posedge clk);
    endtask

    // hand back a credit for each record until all expected ones arrived
    task automatic settle_records();
        while (credits_returned < rec_target) begin
            wait_records(credits_returned + 1);
            return_credits(1);
        end
    endtask

    task automatic read_stat(input logic [STAT_ADDR_WIDTH-1:0] addr,
                             output logic [STAT_WIDTH-1:0] data);
        @(negedge clk);
        stat_rd   = 1'b1;
        stat_addr = addr;
        @(negedge clk);
        stat_rd = 1'b0;
        if (stat_data_valid !== 1'b1) begin
            stop_run("stat_data_valid did not rise the cycle after a statistic read");
        end
        data = stat_data;
    endtask

    function automatic logic [STAT_WIDTH-1:0] expected_stat(input logic [STAT_ADDR_WIDTH-1:0] a);
        case (a)
            STAT_COMPLETIONS: return m_completions;
            STAT_BYTES:       return m_bytes;
            STAT_ERRORS:      return m_errors;
            STAT_LAT_SUM:     return m_lat_sum;
            STAT_LAT_MAX:     return m_lat_max;
            STAT_DROPS:       return m_drops;
            default:          return '0;
        endcase
    endfunction

    task automatic test_reset();
        logic [STAT_WIDTH-1:0] data;
        repeat (5) begin
            @(negedge clk);
            if (rec_valid !== 1'b0) begin
                stop_run("rec_valid was not low after reset");
            end
            if (stat_data_valid !== 1'b0) begin
                stop_run("stat_data_valid was not low after reset");
            end
        end
        for (int a = 0; a < 8; a++) begin
            read_stat(STAT_ADDR_WIDTH'(a), data);
            check_stat(STAT_ADDR_WIDTH'(a), '0, data);  // all zero, 6 and 7 included
        end
    endtask

    task automatic test_single();
        logic [TAG_WIDTH-1:0] tag;
        for (int i = 0; i < 5; i++) begin
            tag = TAG_WIDTH'(i + 1);
            drive_start(tag, LEN_WIDTH'($urandom_range(1, 4096)));
            idle($urandom_range(1, 20));              // random latency
            drive_finish(tag, '0, 1'b1);
            settle_records();
        end
    endtask

    task automatic test_interleaved();
        logic [TAG_WIDTH-1:0]    order [6];
        logic [STATUS_WIDTH-1:0] status;
        order = '{8'd13, 8'd10, 8'd15, 8'd11, 8'd14, 8'd12};
        for (int i = 0; i < 6; i++) begin
            drive_start(TAG_WIDTH'(10 + i), LEN_WIDTH'($urandom));
            idle($urandom_range(0, 5));
        end
        for (int i = 0; i < 6; i++) begin
            status = (i % 2 == 1) ? STATUS_WIDTH'($urandom_range(1, 15)) : '0;
            drive_finish(order[i], status, 1'b1);
            idle($urandom_range(0, 3));
        end
        settle_records();                             // monitor checks finish order
    endtask

    task automatic test_backpressure();
        int base;
        base = rec_count;
        for (int i = 0; i < 6; i++) begin
            drive_start(TAG_WIDTH'(20 + i), LEN_WIDTH'($urandom_range(1, 1024)));
        end
        for (int i = 0; i < 6; i++) begin
            drive_finish(TAG_WIDTH'(20 + i), '0, 1'b1);
        end
        wait_records(base + REC_CREDITS);
        repeat (20) begin
            @(negedge clk);
            if (rec_valid !== 1'b0) begin
                stop_run("a record was sent while the sender held no credit");
            end
        end
        return_credits(2);
        wait_records(base + REC_CREDITS + 2);
        idle(10);
        if (rec_count != base + REC_CREDITS + 2) begin
            stop_run("more records left than the two returned credits allow");
        end
    endtask

    // sender holds zero credits on entry, left so by the previous test
    task automatic test_overflow();
        logic [STAT_WIDTH-1:0] data;
        for (int i = 0; i < BURST; i++) begin
            drive_start(TAG_WIDTH'(30 + i), LEN_WIDTH'($urandom_range(1, 2048)));
        end
        for (int i = 0; i < BURST; i++) begin
            drive_finish(TAG_WIDTH'(30 + i), STATUS_WIDTH'($urandom_range(0, 3)), i < FIFO_DEPTH);
        end
        settle_records();
        idle(10);
        if (exp_q.size() != 0 || rec_count != rec_target) begin
            stop_run("the overflow burst delivered a wrong number of records");
        end
        read_stat(STAT_DROPS, data);
        check_stat(STAT_DROPS, m_drops, data);
    endtask

    task automatic test_readout();
        logic [STAT_WIDTH-1:0] data;
        for (int a = 0; a < 6; a++) begin
            read_stat(STAT_ADDR_WIDTH'(a), data);
            check_stat(STAT_ADDR_WIDTH'(a), expected_stat(STAT_ADDR_WIDTH'(a)), data);
        end
    endtask

    initial begin
        void'($urandom(32'h2fed5879));
        clk           = 1'b0;
        rst           = 1'b1;
        start_tag     = '0;
        start_len     = '0;
        start_valid   = 1'b0;
        finish_tag    = '0;
        finish_status = '0;
        finish_valid  = 1'b0;
        stat_rd       = 1'b0;
        stat_addr     = '0;
        rec_credit    = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_single();
        test_interleaved();
        test_backpressure();
        test_overflow();
        test_readout();
        idle(5);
        $display("test passed");
        $finish;
    end

endmodule

//--- verilog/dma_stats_top.sv
`timescale 1ns/10ps

module dma_stats_top (
    input  logic                                        clk,
    input  logic                                        rst,

    input  logic [dma_stats_pkg::TAG_WIDTH-1:0]         start_tag,
    input  logic [dma_stats_pkg::LEN_WIDTH-1:0]         start_len,
    input  logic                                        start_valid,
    input  logic [dma_stats_pkg::TAG_WIDTH-1:0]         finish_tag,
    input  logic [dma_stats_pkg::STATUS_WIDTH-1:0]      finish_status,
    input  logic                                        finish_valid,

    input  logic                                        stat_rd,
    input  logic [dma_stats_pkg::STAT_ADDR_WIDTH-1:0]   stat_addr,
    output logic [dma_stats_pkg::STAT_WIDTH-1:0]        stat_data,
    output logic                                        stat_data_valid,

    input  logic                                        rec_credit,
    output logic [dma_stats_pkg::TAG_WIDTH-1:0]         rec_tag,
    output logic [dma_stats_pkg::LEN_WIDTH-1:0]         rec_len,
    output logic [dma_stats_pkg::STATUS_WIDTH-1:0]      rec_status,
    output logic [dma_stats_pkg::COUNT_WIDTH-1:0]       rec_latency,
    output logic                                        rec_valid
);

    import dma_stats_pkg::*;

    logic [TAG_WIDTH-1:0]    lat_tag;           // record from the latency block
    logic [LEN_WIDTH-1:0]    lat_len;
    logic [STATUS_WIDTH-1:0] lat_status;
    logic [COUNT_WIDTH-1:0]  lat_latency;
    logic                    lat_valid;

    logic [TAG_WIDTH-1:0]    head_tag;          // fifo head to sender
    logic [LEN_WIDTH-1:0]    head_len;
    logic [STATUS_WIDTH-1:0] head_status;
    logic [COUNT_WIDTH-1:0]  head_latency;
    logic                    fifo_empty;
    logic                    fifo_pop;
    logic                    fifo_overflow;     // drop pulse to statistics

    stats_dma_latency stats_dma_latency_i (.*);

    stats_record_fifo stats_record_fifo_i (
        .clk, .rst,
        .in_tag(lat_tag), .in_len(lat_len), .in_status(lat_status),
        .in_latency(lat_latency), .in_valid(lat_valid),
        .fifo_pop, .head_tag, .head_len, .head_status, .head_latency,
        .fifo_empty, .fifo_overflow
    );

    stats_credit_tx stats_credit_tx_i (.*);

    stats_accum stats_accum_i (
        .clk, .rst,
        .lat_len, .lat_status, .lat_latency, .lat_valid,
        .fifo_overflow,
        .stat_rd, .stat_addr, .stat_data, .stat_data_valid
    );

endmodule

//--- verilog/stats_accum.sv
`timescale 1ns/10ps

module stats_accum (
    input  logic                                        clk,
    input  logic                                        rst,

    input  logic [dma_stats_pkg::LEN_WIDTH-1:0]         lat_len,
    input  logic [dma_stats_pkg::STATUS_WIDTH-1:0]      lat_status,
    input  logic [dma_stats_pkg::COUNT_WIDTH-1:0]       lat_latency,
    input  logic                                        lat_valid,

    input  logic                                        fifo_overflow,

    input  logic                                        stat_rd,
    input  logic [dma_stats_pkg::STAT_ADDR_WIDTH-1:0]   stat_addr,
    output logic [dma_stats_pkg::STAT_WIDTH-1:0]        stat_data,
    output logic                                        stat_data_valid
);

    import dma_stats_pkg::*;

    logic [STAT_WIDTH-1:0] completions;     // records seen
    logic [STAT_WIDTH-1:0] bytes;           // sum of lengths
    logic [STAT_WIDTH-1:0] errors;          // nonzero status count
    logic [STAT_WIDTH-1:0] lat_sum;         // sum of latencies
    logic [STAT_WIDTH-1:0] lat_max;         // largest latency so far
    logic [STAT_WIDTH-1:0] drops;           // records lost at the fifo

    logic [STAT_WIDTH-1:0] len_ext;         // zero-extended record fields
    logic [STAT_WIDTH-1:0] lat_ext;
    logic                  is_error;
    logic [STAT_WIDTH-1:0] rd_mux;          // selected statistic

    assign len_ext  = STAT_WIDTH'(lat_len);
    assign lat_ext  = STAT_WIDTH'(lat_latency);
    assign is_error = (lat_status != '0);   // zero means success

    // record driven totals
    always_ff @(posedge clk) begin
        if (rst) begin
            completions <= '0;
            bytes       <= '0;
            errors      <= '0;
            lat_sum     <= '0;
            lat_max     <= '0;
        end else if (lat_valid) begin
            completions <= completions + 1'b1;
            bytes       <= bytes + len_ext;
            lat_sum     <= lat_sum + lat_ext;
            if (is_error) begin
                errors <= errors + 1'b1;
            end
            if (lat_ext > lat_max) begin
                lat_max <= lat_ext;             // only ever rises
            end
        end
    end

    // drops come from the fifo, independent of lat_valid
    always_ff @(posedge clk) begin
        if (rst) begin
            drops <= '0;
        end else if (fifo_overflow) begin
            drops <= drops + 1'b1;
        end
    end

    // read address decode
    always_comb begin
        case (stat_addr)
            STAT_COMPLETIONS: rd_mux = completions;
            STAT_BYTES:       rd_mux = bytes;
            STAT_ERRORS:      rd_mux = errors;
            STAT_LAT_SUM:     rd_mux = lat_sum;
            STAT_LAT_MAX:     rd_mux = lat_max;
            STAT_DROPS:       rd_mux = drops;
            default:          rd_mux = '0;      // 6, 7 unused
        endcase
    end

    // registered read port, data the edge after stat_rd
    always_ff @(posedge clk) begin
        if (rst) begin
            stat_data_valid <= 1'b0;
        end else begin
            stat_data_valid <= stat_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (stat_rd) begin
            stat_data <= rd_mux;                // held until next read
        end
    end

endmodule

//--- verilog/stats_credit_tx.sv
`timescale 1ns/10ps

module stats_credit_tx (
    input  logic                                    clk,
    input  logic                                    rst,

    input  logic [dma_stats_pkg::TAG_WIDTH-1:0]     head_tag,
    input  logic [dma_stats_pkg::LEN_WIDTH-1:0]     head_len,
    input  logic [dma_stats_pkg::STATUS_WIDTH-1:0]  head_status,
    input  logic [dma_stats_pkg::COUNT_WIDTH-1:0]   head_latency,
    input  logic                                    fifo_empty,
    output logic                                    fifo_pop,

    input  logic                                    rec_credit,
    output logic [dma_stats_pkg::TAG_WIDTH-1:0]     rec_tag,
    output logic [dma_stats_pkg::LEN_WIDTH-1:0]     rec_len,
    output logic [dma_stats_pkg::STATUS_WIDTH-1:0]  rec_status,
    output logic [dma_stats_pkg::COUNT_WIDTH-1:0]   rec_latency,
    output logic                                    rec_valid
);

    import dma_stats_pkg::*;

    logic [CREDIT_WIDTH-1:0] credits;       // 0..REC_CREDITS

    // spend at the pop, so the count is already low while rec_valid is up
    assign fifo_pop = !fifo_empty && (credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_WIDTH'(REC_CREDITS);      // full after reset
        end else begin
            case ({fifo_pop, rec_credit})
                2'b10:   credits <= credits - 1'b1;     // spend
                2'b01:   credits <= credits + 1'b1;     // return
                default: credits <= credits;            // none, or both cancel
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= fifo_pop;                      // single cycle per pop
        end
    end

    // output payload register
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            rec_tag     <= head_tag;
            rec_len     <= head_len;
            rec_status  <= head_status;
            rec_latency <= head_latency;
        end
    end

endmodule

//--- verilog/stats_record_fifo.sv
`timescale 1ns/10ps

module stats_record_fifo (
    input  logic                                    clk,
    input  logic                                    rst,

    input  logic [dma_stats_pkg::TAG_WIDTH-1:0]     in_tag,
    input  logic [dma_stats_pkg::LEN_WIDTH-1:0]     in_len,
    input  logic [dma_stats_pkg::STATUS_WIDTH-1:0]  in_status,
    input  logic [dma_stats_pkg::COUNT_WIDTH-1:0]   in_latency,
    input  logic                                    in_valid,

    input  logic                                    fifo_pop,
    output logic [dma_stats_pkg::TAG_WIDTH-1:0]     head_tag,
    output logic [dma_stats_pkg::LEN_WIDTH-1:0]     head_len,
    output logic [dma_stats_pkg::STATUS_WIDTH-1:0]  head_status,
    output logic [dma_stats_pkg::COUNT_WIDTH-1:0]   head_latency,
    output logic                                    fifo_empty,
    output logic                                    fifo_overflow
);

    import dma_stats_pkg::*;

    logic [TAG_WIDTH-1:0]    tag_mem    [FIFO_DEPTH];    // record storage, one array per field
    logic [LEN_WIDTH-1:0]    len_mem    [FIFO_DEPTH];
    logic [STATUS_WIDTH-1:0] status_mem [FIFO_DEPTH];
    logic [COUNT_WIDTH-1:0]  lat_mem    [FIFO_DEPTH];

    logic [FIFO_PTR_WIDTH-1:0]   wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0]   rd_ptr;
    logic [FIFO_COUNT_WIDTH-1:0] count;                  // occupancy

    logic full;
    logic do_pop;
    logic do_write;

    assign fifo_empty = (count == '0);
    assign full       = (count == FIFO_COUNT_WIDTH'(FIFO_DEPTH));
    assign do_pop     = fifo_pop && !fifo_empty;
    assign do_write   = in_valid && (!full || do_pop);   // pop frees a slot this edge

    // head straight from memory
    assign head_tag     = tag_mem[rd_ptr];
    assign head_len     = len_mem[rd_ptr];
    assign head_status  = status_mem[rd_ptr];
    assign head_latency = lat_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            tag_mem[wr_ptr]    <= in_tag;
            len_mem[wr_ptr]    <= in_len;
            status_mem[wr_ptr] <= in_status;
            lat_mem[wr_ptr]    <= in_latency;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            fifo_overflow <= 1'b0;
        end else begin
            wr_ptr        <= wr_ptr + FIFO_PTR_WIDTH'(do_write);    // depth is a power of two
            rd_ptr        <= rd_ptr + FIFO_PTR_WIDTH'(do_pop);
            count         <= count + FIFO_COUNT_WIDTH'(do_write) - FIFO_COUNT_WIDTH'(do_pop);
            fifo_overflow <= in_valid && !do_write;             // record discarded
        end
    end

endmodule

//--- verilog/stats_dma_latency.sv
`timescale 1ns/10ps

module stats_dma_latency (
    input  logic                                    clk,
    input  logic                                    rst,

    input  logic [dma_stats_pkg::TAG_WIDTH-1:0]     start_tag,
    input  logic [dma_stats_pkg::LEN_WIDTH-1:0]     start_len,
    input  logic                                    start_valid,

    input  logic [dma_stats_pkg::TAG_WIDTH-1:0]     finish_tag,
    input  logic [dma_stats_pkg::STATUS_WIDTH-1:0]  finish_status,
    input  logic                                    finish_valid,

    output logic [dma_stats_pkg::TAG_WIDTH-1:0]     lat_tag,
    output logic [dma_stats_pkg::LEN_WIDTH-1:0]     lat_len,
    output logic [dma_stats_pkg::STATUS_WIDTH-1:0]  lat_status,
    output logic [dma_stats_pkg::COUNT_WIDTH-1:0]   lat_latency,
    output logic                                    lat_valid
);

    import dma_stats_pkg::*;

    logic [COUNT_WIDTH-1:0] count;                    // free-running cycle count

    logic [LEN_WIDTH-1:0]   len_mem   [TAG_DEPTH];    // length per tag
    logic [COUNT_WIDTH-1:0] start_mem [TAG_DEPTH];    // start time per tag

    logic [LEN_WIDTH-1:0]   rd_len;                   // stored length of finishing tag
    logic [COUNT_WIDTH-1:0] rd_start;                 // stored start of finishing tag

    // async read, sees the entry before any write at this edge
    assign rd_len   = len_mem[finish_tag];
    assign rd_start = start_mem[finish_tag];

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;                    // wraps mod 2^COUNT_WIDTH
        end
    end

    // tag memories, contents survive reset
    always_ff @(posedge clk) begin
        if (start_valid) begin
            len_mem[start_tag]   <= start_len;
            start_mem[start_tag] <= count;            // edge that sampled the start
        end
    end

    // one record per finish, valid the cycle after
    always_ff @(posedge clk) begin
        if (rst) begin
            lat_tag     <= '0;
            lat_len     <= '0;
            lat_status  <= '0;
            lat_latency <= '0;
            lat_valid   <= 1'b0;
        end else begin
            lat_valid <= finish_valid;
            if (finish_valid) begin
                lat_tag     <= finish_tag;
                lat_len     <= rd_len;
                lat_status  <= finish_status;
                lat_latency <= count - rd_start;      // modular difference
            end
        end
    end

endmodule

//--- verilog/dma_stats_pkg.sv
package dma_stats_pkg;

    // event and record field widths
    localparam int COUNT_WIDTH  = 16;                 // cycle counter, latency wraps mod 2^16
    localparam int TAG_WIDTH    = 8;                  // dma tag
    localparam int LEN_WIDTH    = 16;                 // transfer length in bytes
    localparam int STATUS_WIDTH = 4;                  // completion status, 0 = ok

    localparam int TAG_DEPTH = 2 ** TAG_WIDTH;        // one memory entry per tag

    // statistics
    localparam int STAT_WIDTH      = 32;              // every statistic wraps
    localparam int STAT_ADDR_WIDTH = 3;               // host read address

    // read map, 6 and 7 read zero
    localparam logic [STAT_ADDR_WIDTH-1:0] STAT_COMPLETIONS = 3'd0;
    localparam logic [STAT_ADDR_WIDTH-1:0] STAT_BYTES       = 3'd1;
    localparam logic [STAT_ADDR_WIDTH-1:0] STAT_ERRORS      = 3'd2;
    localparam logic [STAT_ADDR_WIDTH-1:0] STAT_LAT_SUM     = 3'd3;
    localparam logic [STAT_ADDR_WIDTH-1:0] STAT_LAT_MAX     = 3'd4;
    localparam logic [STAT_ADDR_WIDTH-1:0] STAT_DROPS       = 3'd5;

    // record fifo
    localparam int FIFO_DEPTH       = 8;                    // records held
    localparam int FIFO_PTR_WIDTH   = 3;                    // wraps exactly at depth
    localparam int FIFO_COUNT_WIDTH = FIFO_PTR_WIDTH + 1;   // 0..FIFO_DEPTH

    // credit flow control toward the consumer
    localparam int REC_CREDITS  = 4;                        // initial and max credits
    localparam int CREDIT_WIDTH = $clog2(REC_CREDITS + 1);  // 0..REC_CREDITS

endpackage
